// ==== vlog.f ====
hw/msu_pkg.sv
hw/msu_edge_detect.sv
hw/msu_databuf.sv
hw/msu_data_port.sv
hw/msu_regs.sv
hw/msu_top.sv
test/msu_asserts.sv
test/msu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= msu_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	-$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/msu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module msu_tb import msu_pkg::*; ();

  localparam int SYNC_STAGES = MSU_SYNC_STAGES;
  localparam int BUF_AW      = MSU_BUF_AW;
  localparam int HOLD        = SYNC_STAGES + 2;
  localparam int CLK_NS      = 8;
  localparam int N_DATA      = 12;
  // Upper bound on strobe cycles over all tests
  localparam int BUS_OPS     = 64;
  localparam int WATCHDOG_NS = BUS_OPS * 2 * HOLD * CLK_NS + 16 * CLK_NS + 2000;

  logic              clkin = 1'b0;
  logic              reset;
  logic              enable;
  logic [BUF_AW-1:0] pgm_address;
  logic [7:0]        pgm_data;
  logic              pgm_we;
  logic [2:0]        reg_addr;
  logic [7:0]        reg_data_in;
  logic [7:0]        reg_data_out;
  logic              reg_oe;
  logic              reg_we;
  msu_status_t       status_out;
  logic [7:0]        volume_out;
  logic              volume_latch_out;
  logic [31:0]       addr_out;
  logic [15:0]       track_out;
  msu_status_upd_t   status_upd;
  logic              status_reset_we;
  logic [BUF_AW-1:0] msu_address_ext;
  logic              msu_address_ext_write;

  // Reference model state
  logic       exp_data_busy;
  logic       exp_audio_busy;
  logic       exp_data_start;
  logic       exp_audio_start;
  logic       exp_ctrl_start;
  logic [1:0] exp_audio_status;
  logic [1:0] exp_audio_ctrl;
  logic [7:0] ref_mem [logic [BUF_AW-1:0]];

  logic [31:0] rng_state = 32'hb09e;
  int          latch_pulses = 0;
  int          vstart_pulses = 0;

  always #(CLK_NS / 2) clkin = ~clkin;

  msu_top #(
    .SYNC_STAGES(SYNC_STAGES),
    .BUF_AW(BUF_AW)
  ) DUT (.*);

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Status byte from data busy, audio busy, audio status, error bit and revision 001
  function automatic logic [7:0] status_byte();
    return {exp_data_busy, exp_audio_busy, exp_audio_status, 1'b0, 3'b001};
  endfunction

  function automatic int assert_fail_count();
    return DUT.u_asserts.latch_fails + DUT.u_asserts.start_fails
           + DUT.u_asserts.stable_fails;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_hex(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic bus_write(input logic [2:0] addr, input logic [7:0] data);
    @(negedge clkin);
    reg_addr    = addr;
    reg_data_in = data;
    reg_we      = 1'b1;
    repeat (HOLD) @(negedge clkin);
    reg_we = 1'b0;
    repeat (HOLD) @(negedge clkin);
  endtask

  task automatic bus_read(input logic [2:0] addr, output logic [7:0] data);
    @(negedge clkin);
    reg_addr = addr;
    reg_oe   = 1'b1;
    repeat (HOLD) @(negedge clkin);
    data   = reg_data_out;
    reg_oe = 1'b0;
    repeat (HOLD) @(negedge clkin);
  endtask

  task automatic ext_load(input logic [BUF_AW-1:0] addr);
    @(negedge clkin);
    msu_address_ext       = addr;
    msu_address_ext_write = 1'b1;
    repeat (HOLD) @(negedge clkin);
    msu_address_ext_write = 1'b0;
    repeat (HOLD) @(negedge clkin);
  endtask

  task automatic program_byte(input logic [BUF_AW-1:0] addr, input logic [7:0] data);
    @(negedge clkin);
    pgm_address = addr;
    pgm_data    = data;
    pgm_we      = 1'b1;
    @(negedge clkin);
    pgm_we = 1'b0;
    ref_mem[addr] = data;
  endtask

  task automatic status_update(input logic [5:0] set, input logic [5:0] clr);
    @(negedge clkin);
    status_upd.set_bits = set;
    status_upd.clr_bits = clr;
    status_reset_we     = 1'b1;
    repeat (HOLD) @(negedge clkin);
    status_reset_we = 1'b0;
    repeat (HOLD) @(negedge clkin);
    status_upd = '0;
    // Set before clear
    // A busy clear also drops its start flag
    exp_audio_busy = (exp_audio_busy | set[5]) & ~clr[5];
    if (clr[5]) begin
      exp_audio_start = 1'b0;
    end
    exp_data_busy = (exp_data_busy | set[4]) & ~clr[4];
    if (clr[4]) begin
      exp_data_start = 1'b0;
    end
    exp_audio_status = (exp_audio_status | set[2:1]) & ~clr[2:1];
    exp_ctrl_start   = (exp_ctrl_start | set[0]) & ~clr[0];
  endtask

  task automatic check_flags();
    logic [7:0] got;
    check_hex("status_out.data_start", 32'(status_out.data_start), 32'(exp_data_start));
    check_hex("status_out.audio_start", 32'(status_out.audio_start), 32'(exp_audio_start));
    check_hex("status_out.ctrl_start", 32'(status_out.ctrl_start), 32'(exp_ctrl_start));
    check_hex("status_out.audio_ctrl", 32'(status_out.audio_ctrl), 32'(exp_audio_ctrl));
    bus_read(RD_STATUS, got);
    check_hex("reg_data_out", 32'(got), 32'(status_byte()));
  endtask

  // Volume strobe pulses seen at the falling edge
  always @(negedge clkin) begin
    if (!reset && volume_latch_out) begin
      latch_pulses = latch_pulses + 1;
    end
    if (!reset && status_out.volume_start) begin
      vstart_pulses = vstart_pulses + 1;
    end
  end

  always @(negedge clkin) begin
    if (assert_fail_count() != 0) begin
      abort_run("An assertion in msu_asserts failed");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("Timeout, the tests did not finish in time");
  end

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    logic [31:0]       r;
    logic [7:0]        got;
    logic [31:0]       addr_val;
    logic [15:0]       track_val;
    logic [7:0]        vol_val;
    logic [7:0]        ctrl_val;
    logic [BUF_AW-1:0] base;
    logic [BUF_AW-1:0] ptr;
    int                pulses_before;
    int                vstart_before;

    reset                 = 1'b1;
    enable                = 1'b1;
    pgm_address           = '0;
    pgm_data              = '0;
    pgm_we                = 1'b0;
    reg_addr              = '0;
    reg_data_in           = '0;
    reg_oe                = 1'b0;
    reg_we                = 1'b0;
    status_upd            = '0;
    status_reset_we       = 1'b0;
    msu_address_ext       = '0;
    msu_address_ext_write = 1'b0;
    exp_data_busy         = 1'b1;
    exp_audio_busy        = 1'b1;
    exp_data_start        = 1'b0;
    exp_audio_start       = 1'b0;
    exp_ctrl_start        = 1'b0;
    exp_audio_status      = 2'b00;
    exp_audio_ctrl        = 2'b00;

    repeat (16) @(negedge clkin);
    reset = 1'b0;
    // Let the enable synchronizer fill
    repeat (SYNC_STAGES + 1) @(negedge clkin);

    // Identification string and status after reset
    for (int i = 0; i < 6; i++) begin
      bus_read(3'(RD_ID_BASE + 3'(i)), got);
      check_hex("reg_data_out", 32'(got), 32'(MSU_ID[i]));
    end
    bus_read(RD_STATUS, got);
    check_hex("reg_data_out", 32'(got), 32'h0000_00c1);

    // Seek address
    addr_val = next_rand();
    for (int i = 0; i < 4; i++) begin
      bus_write(3'(i), addr_val[8*i +: 8]);
    end
    exp_data_start = 1'b1;
    exp_data_busy  = 1'b1;
    check_hex("addr_out", addr_out, addr_val);
    check_flags();
    status_update(6'b000000, 6'b010000);
    check_flags();

    // Track and play control
    r         = next_rand();
    track_val = r[15:0];
    bus_write(REG_TRACK0, track_val[7:0]);
    bus_write(REG_TRACK1, track_val[15:8]);
    exp_audio_start = 1'b1;
    exp_audio_busy  = 1'b1;
    check_hex("track_out", 32'(track_out), 32'(track_val));
    check_flags();
    r        = next_rand();
    ctrl_val = r[7:0] | 8'h01;
    bus_write(REG_CTRL, ctrl_val);
    check_flags();
    status_update(6'b000000, 6'b100000);
    check_flags();
    bus_write(REG_CTRL, ctrl_val);
    exp_audio_ctrl = ctrl_val[1:0];
    exp_ctrl_start = 1'b1;
    check_flags();

    // Volume
    r             = next_rand();
    vol_val       = r[7:0];
    pulses_before = latch_pulses;
    vstart_before = vstart_pulses;
    bus_write(REG_VOLUME, vol_val);
    check_hex("volume_out", 32'(volume_out), 32'(vol_val));
    check_hex("volume_latch_out pulses", 32'(latch_pulses - pulses_before), 32'd1);
    check_hex("status_out.volume_start pulses", 32'(vstart_pulses - vstart_before), 32'd1);

    // Data stream across the pointer's top bit
    r    = next_rand();
    base = (BUF_AW'(1) << (BUF_AW - 1)) - BUF_AW'(N_DATA / 2) + BUF_AW'(r[1:0]);
    for (int i = 0; i < N_DATA; i++) begin
      r = next_rand();
      program_byte(base + BUF_AW'(i), r[7:0]);
    end
    ext_load(base);
    ptr = base;
    for (int i = 0; i < N_DATA; i++) begin
      bus_read(RD_DATA, got);
      check_hex("reg_data_out", 32'(got), 32'(ref_mem[ptr]));
      ptr = ptr + BUF_AW'(1);
      check_hex("status_out.addr_msb", 32'(status_out.addr_msb), 32'(ptr[BUF_AW-1]));
    end

    // Audio status set and clear with clear winning on a shared bit
    status_update(6'b000110, 6'b000000);
    check_flags();
    status_update(6'b000000, 6'b000100);
    check_flags();
    status_update(6'b000110, 6'b000010);
    check_flags();

    repeat (4) @(negedge clkin);
    if (assert_fail_count() == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      abort_run("An assertion in msu_asserts failed");
    end
  end

endmodule

`default_nettype wire

// ==== test/msu_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module msu_asserts import msu_pkg::*; (
  input logic        clkin,
  input logic        reset,
  input msu_edges_t  edges,
  input msu_status_t status_out,
  input logic        volume_latch_out,
  input logic        data_busy,
  input logic        audio_busy
);

  // Failure counts, read by the testbench
  int latch_fails  = 0;
  int start_fails  = 0;
  int stable_fails = 0;

  // volume_start trails the write edge by one cycle, so it is left out here
  msu_status_t status_held;

  always_comb begin
    status_held = status_out;
    status_held.volume_start = 1'b0;
  end

  //////////////////////////////////////////////////
  // Properties
  //////////////////////////////////////////////////

  latch_one_cycle: assert property (@(posedge clkin) disable iff (reset)
    volume_latch_out |=> !volume_latch_out)
    else begin
      latch_fails = latch_fails + 1;
      $error("volume_latch_out stayed high for more than one cycle");
    end

  data_start_busy: assert property (@(posedge clkin) disable iff (reset)
    $rose(status_out.data_start) |-> data_busy)
    else begin
      start_fails = start_fails + 1;
      $error("data_start rose without data busy");
    end

  audio_start_busy: assert property (@(posedge clkin) disable iff (reset)
    $rose(status_out.audio_start) |-> audio_busy)
    else begin
      start_fails = start_fails + 1;
      $error("audio_start rose without audio busy");
    end

  // Nothing moves in status_out without an edge pulse
  status_quiet: assert property (@(posedge clkin) disable iff (reset)
    (edges == '0) |=> $stable(status_held))
    else begin
      stable_fails = stable_fails + 1;
      $error("status_out changed without an edge pulse");
    end

endmodule

bind msu_top msu_asserts u_asserts (
  .clkin            (clkin),
  .reset            (reset),
  .edges            (edges),
  .status_out       (status_out),
  .volume_latch_out (volume_latch_out),
  .data_busy        (u_regs.data_busy),
  .audio_busy       (u_regs.audio_busy)
);

`default_nettype wire

// ==== hw/msu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module msu_top import msu_pkg::*; #(
  parameter int SYNC_STAGES = MSU_SYNC_STAGES,
  parameter int BUF_AW      = MSU_BUF_AW
) (
  input  logic              clkin,
  input  logic              reset,
  input  logic              enable,
  input  logic [BUF_AW-1:0] pgm_address,
  input  logic [7:0]        pgm_data,
  input  logic              pgm_we,
  input  logic [2:0]        reg_addr,
  input  logic [7:0]        reg_data_in,
  output logic [7:0]        reg_data_out,
  input  logic              reg_oe,
  input  logic              reg_we,
  output msu_status_t       status_out,
  output logic [7:0]        volume_out,
  output logic              volume_latch_out,
  output logic [31:0]       addr_out,
  output logic [15:0]       track_out,
  input  msu_status_upd_t   status_upd,
  input  logic              status_reset_we,
  input  logic [BUF_AW-1:0] msu_address_ext,
  input  logic              msu_address_ext_write
);

  msu_edges_t        edges;
  logic [BUF_AW-1:0] buf_addr;
  logic [7:0]        buf_data;
  logic              read_sel_data;

  msu_edge_detect #(
    .SYNC_STAGES(SYNC_STAGES)
  ) u_edge_detect (
    .clkin     (clkin),
    .reset     (reset),
    .enable    (enable),
    .reg_oe    (reg_oe),
    .reg_we    (reg_we),
    .ext_write (msu_address_ext_write),
    .stat_we   (status_reset_we),
    .edges     (edges)
  );

  msu_databuf #(
    .BUF_AW(BUF_AW)
  ) u_databuf (
    .clkin       (clkin),
    .pgm_we      (pgm_we),
    .pgm_address (pgm_address),
    .pgm_data    (pgm_data),
    .rd_address  (buf_addr),
    .rd_data     (buf_data)
  );

  msu_data_port #(
    .BUF_AW(BUF_AW)
  ) u_data_port (
    .clkin         (clkin),
    .reset         (reset),
    .edges         (edges),
    .read_sel_data (read_sel_data),
    .address_ext   (msu_address_ext),
    .buf_addr      (buf_addr)
  );

  msu_regs #(
    .SYNC_STAGES(SYNC_STAGES)
  ) u_regs (
    .clkin            (clkin),
    .reset            (reset),
    .edges            (edges),
    .reg_addr         (reg_addr),
    .reg_data_in      (reg_data_in),
    .reg_data_out     (reg_data_out),
    .buf_data         (buf_data),
    .addr_msb         (buf_addr[BUF_AW-1]),
    .status_upd       (status_upd),
    .read_sel_data    (read_sel_data),
    .addr_out         (addr_out),
    .track_out        (track_out),
    .volume_out       (volume_out),
    .volume_latch_out (volume_latch_out),
    .status_out       (status_out)
  );

endmodule

`default_nettype wire

// ==== hw/msu_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module msu_regs import msu_pkg::*; #(
  parameter int SYNC_STAGES = MSU_SYNC_STAGES
) (
  input  logic            clkin,
  input  logic            reset,
  input  msu_edges_t      edges,
  input  logic [2:0]      reg_addr,
  input  logic [7:0]      reg_data_in,
  output logic [7:0]      reg_data_out,
  input  logic [7:0]      buf_data,
  input  logic            addr_msb,
  input  msu_status_upd_t status_upd,
  output logic            read_sel_data,
  output logic [31:0]     addr_out,
  output logic [15:0]     track_out,
  output logic [7:0]      volume_out,
  output logic            volume_latch_out,
  output msu_status_t     status_out
);

  logic [2:0] addr_dly [SYNC_STAGES];
  logic [2:0] addr_sel;
  logic [2:0] id_idx;

  logic       audio_start;
  logic       audio_busy;
  logic       data_start;
  logic       data_busy;
  logic       ctrl_start;
  logic [1:0] audio_ctrl;
  logic [1:0] audio_status;

  //////////////////////////////////////////////////
  // Address delay, lines up with the edge pulses
  //////////////////////////////////////////////////

  always_ff @(posedge clkin) begin
    if (reset) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        addr_dly[i] <= '0;
      end
    end else begin
      addr_dly[0] <= reg_addr;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        addr_dly[i] <= addr_dly[i-1];
      end
    end
  end

  assign addr_sel      = addr_dly[SYNC_STAGES-1];
  assign read_sel_data = (addr_sel == RD_DATA);
  assign id_idx        = addr_sel - RD_ID_BASE;

  //////////////////////////////////////////////////
  // Command registers and status flags
  //////////////////////////////////////////////////

  // A console write in the same cycle masks the controller update
  always_ff @(posedge clkin) begin
    if (reset) begin
      addr_out     <= '0;
      track_out    <= '0;
      volume_out   <= '0;
      audio_start  <= 1'b0;
      data_start   <= 1'b0;
      ctrl_start   <= 1'b0;
      audio_ctrl   <= '0;
      audio_status <= '0;
      audio_busy   <= 1'b1;
      data_busy    <= 1'b1;
    end else if (edges.we_rise) begin
      unique case (msu_reg_e'(addr_sel))
        REG_ADDR0:  addr_out[7:0]   <= reg_data_in;
        REG_ADDR1:  addr_out[15:8]  <= reg_data_in;
        REG_ADDR2:  addr_out[23:16] <= reg_data_in;
        REG_ADDR3: begin
          addr_out[31:24] <= reg_data_in;
          data_start      <= 1'b1;
          data_busy       <= 1'b1;
        end
        REG_TRACK0: track_out[7:0]  <= reg_data_in;
        REG_TRACK1: begin
          track_out[15:8] <= reg_data_in;
          audio_start     <= 1'b1;
          audio_busy      <= 1'b1;
        end
        REG_VOLUME: volume_out <= reg_data_in;
        REG_CTRL: begin
          // Play control locked out while a track is loading
          if (!audio_busy) begin
            audio_ctrl <= reg_data_in[1:0];
            ctrl_start <= 1'b1;
          end
        end
      endcase
    end else if (edges.stat_rise) begin
      audio_busy <= (audio_busy | status_upd.set_bits[UPD_AUDIO_BUSY])
                    & ~status_upd.clr_bits[UPD_AUDIO_BUSY];
      if (status_upd.clr_bits[UPD_AUDIO_BUSY]) begin
        audio_start <= 1'b0;
      end
      data_busy <= (data_busy | status_upd.set_bits[UPD_DATA_BUSY])
                   & ~status_upd.clr_bits[UPD_DATA_BUSY];
      if (status_upd.clr_bits[UPD_DATA_BUSY]) begin
        data_start <= 1'b0;
      end
      audio_status <= (audio_status | status_upd.set_bits[UPD_AUDIO_STAT +: 2])
                      & ~status_upd.clr_bits[UPD_AUDIO_STAT +: 2];
      ctrl_start <= (ctrl_start | status_upd.set_bits[UPD_CTRL_START])
                    & ~status_upd.clr_bits[UPD_CTRL_START];
    end
  end

  // Single cycle strobe after each volume write
  always_ff @(posedge clkin) begin
    if (reset) begin
      volume_latch_out <= 1'b0;
    end else begin
      volume_latch_out <= edges.we_rise && (addr_sel == REG_VOLUME);
    end
  end

  always_comb begin
    status_out.addr_msb     = addr_msb;
    status_out.audio_start  = audio_start;
    status_out.data_start   = data_start;
    status_out.volume_start = volume_latch_out;
    status_out.audio_ctrl   = audio_ctrl;
    status_out.ctrl_start   = ctrl_start;
  end

  //////////////////////////////////////////////////
  // Readback
  //////////////////////////////////////////////////

  // Status byte ends in the fixed revision 001, audio error never set
  always_ff @(posedge clkin) begin
    case (addr_sel)
      RD_STATUS: reg_data_out <= {data_busy, audio_busy, audio_status, 1'b0, 3'b001};
      RD_DATA:   reg_data_out <= buf_data;
      default:   reg_data_out <= MSU_ID[id_idx];
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/msu_data_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module msu_data_port import msu_pkg::*; #(
  parameter int BUF_AW = MSU_BUF_AW
) (
  input  logic              clkin,
  input  logic              reset,
  input  msu_edges_t        edges,
  input  logic              read_sel_data,
  input  logic [BUF_AW-1:0] address_ext,
  output logic [BUF_AW-1:0] buf_addr
);

  logic data_read;

  // Console read of the data register
  assign data_read = edges.oe_rise & read_sel_data;

  //////////////////////////////////////////////////
  // Buffer read pointer
  //////////////////////////////////////////////////

  // Controller reload wins over an increment, wrap is free at BUF_AW bits
  always_ff @(posedge clkin) begin
    if (reset) begin
      buf_addr <= '0;
    end else if (edges.ext_rise) begin
      buf_addr <= address_ext;
    end else if (data_read) begin
      buf_addr <= buf_addr + BUF_AW'(1);
    end
  end

endmodule

`default_nettype wire

// ==== hw/msu_databuf.sv ====
`timescale 1ns/1ps
`default_nettype none

module msu_databuf #(
  parameter int BUF_AW = 14
) (
  input  logic              clkin,
  input  logic              pgm_we,
  input  logic [BUF_AW-1:0] pgm_address,
  input  logic [7:0]        pgm_data,
  input  logic [BUF_AW-1:0] rd_address,
  output logic [7:0]        rd_data
);

  localparam int DEPTH = 1 << BUF_AW;

  logic [7:0] mem [0:DEPTH-1];

  // Program port from the media controller
  always_ff @(posedge clkin) begin
    if (pgm_we) begin
      mem[pgm_address] <= pgm_data;
    end
  end

  // Registered read, data lags the address by one cycle
  always_ff @(posedge clkin) begin
    rd_data <= mem[rd_address];
  end

endmodule

`default_nettype wire

// ==== hw/msu_edge_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module msu_edge_detect import msu_pkg::*; #(
  parameter int SYNC_STAGES = MSU_SYNC_STAGES
) (
  input  logic       clkin,
  input  logic       reset,
  input  logic       enable,
  input  logic       reg_oe,
  input  logic       reg_we,
  input  logic       ext_write,
  input  logic       stat_we,
  output msu_edges_t edges
);

  // One stage beyond the synchronizer keeps the previous level
  localparam int SR_LEN = SYNC_STAGES + 1;

  logic [SR_LEN-1:0]      oe_sr;
  logic [SR_LEN-1:0]      we_sr;
  logic [SR_LEN-1:0]      ext_sr;
  logic [SR_LEN-1:0]      stat_sr;
  logic [SYNC_STAGES-1:0] en_sr;
  logic                   en_ok;

  always_ff @(posedge clkin) begin
    if (reset) begin
      oe_sr   <= '0;
      we_sr   <= '0;
      ext_sr  <= '0;
      stat_sr <= '0;
      en_sr   <= '0;
    end else begin
      oe_sr[0]   <= reg_oe;
      we_sr[0]   <= reg_we;
      ext_sr[0]  <= ext_write;
      stat_sr[0] <= stat_we;
      en_sr[0]   <= enable;
      for (int i = 1; i < SR_LEN; i++) begin
        oe_sr[i]   <= oe_sr[i-1];
        we_sr[i]   <= we_sr[i-1];
        ext_sr[i]  <= ext_sr[i-1];
        stat_sr[i] <= stat_sr[i-1];
        if (i < SYNC_STAGES) begin
          en_sr[i] <= en_sr[i-1];
        end
      end
    end
  end

  assign en_ok = en_sr[SYNC_STAGES-1];

  // Compare the two oldest stages, console strobes only count while enabled
  always_comb begin
    edges.oe_rise   = en_ok & oe_sr[SR_LEN-2] & ~oe_sr[SR_LEN-1];
    edges.oe_fall   = en_ok & ~oe_sr[SR_LEN-2] & oe_sr[SR_LEN-1];
    edges.we_rise   = en_ok & we_sr[SR_LEN-2] & ~we_sr[SR_LEN-1];
    edges.ext_rise  = ext_sr[SR_LEN-2] & ~ext_sr[SR_LEN-1];
    edges.stat_rise = stat_sr[SR_LEN-2] & ~stat_sr[SR_LEN-1];
  end

endmodule

`default_nettype wire

// ==== hw/msu_pkg.sv ====
`default_nettype none

package msu_pkg;

  // Strobe synchronizer depth and buffer address width
  localparam int MSU_SYNC_STAGES = 3;
  localparam int MSU_BUF_AW = 14;

  // Register addresses as seen on writes
  typedef enum logic [2:0] {
    REG_ADDR0  = 3'd0,
    REG_ADDR1  = 3'd1,
    REG_ADDR2  = 3'd2,
    REG_ADDR3  = 3'd3,
    REG_TRACK0 = 3'd4,
    REG_TRACK1 = 3'd5,
    REG_VOLUME = 3'd6,
    REG_CTRL   = 3'd7
  } msu_reg_e;

  // Read side of the same address space
  localparam logic [2:0] RD_STATUS  = 3'd0;
  localparam logic [2:0] RD_DATA    = 3'd1;
  localparam logic [2:0] RD_ID_BASE = 3'd2;

  // "S-MSU1", byte 0 sits at read address 2
  localparam logic [5:0][7:0] MSU_ID = {8'h31, 8'h55, 8'h53, 8'h4d, 8'h2d, 8'h53};

  // Bit positions in the status set/clear words
  localparam int UPD_W          = 6;
  localparam int UPD_AUDIO_BUSY = 5;
  localparam int UPD_DATA_BUSY  = 4;
  localparam int UPD_AUDIO_STAT = 1;
  localparam int UPD_CTRL_START = 0;

  typedef struct packed {
    logic oe_rise;
    logic oe_fall;
    logic we_rise;
    logic ext_rise;
    logic stat_rise;
  } msu_edges_t;

  typedef struct packed {
    logic [UPD_W-1:0] set_bits;
    logic [UPD_W-1:0] clr_bits;
  } msu_status_upd_t;

  typedef struct packed {
    logic       addr_msb;
    logic       audio_start;
    logic       data_start;
    logic       volume_start;
    logic [1:0] audio_ctrl;
    logic       ctrl_start;
  } msu_status_t;

endpackage

`default_nettype wire
